// ==== source/axi_wr_pkg.sv ====
// AXI4 write path shared types
// Field widths, burst and response codes, arbiter states

package axi_wr_pkg;

  // --------------------------------------------------------------------
  // AXI4 field types
  // --------------------------------------------------------------------

  // Beats in burst minus one
  typedef logic [7:0] axi_len_t;
  // Bytes per beat as a power of two
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_burst_t;
  typedef logic [1:0] axi_resp_t;
  // Region tag, carried but not decoded
  typedef logic [3:0] axi_region_t;

  // Burst kinds, WRAP not supported
  localparam axi_burst_t BURST_FIXED = 2'd0;
  localparam axi_burst_t BURST_INCR  = 2'd1;

  // Write responses
  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  // --------------------------------------------------------------------
  // Arbiter FSM
  // --------------------------------------------------------------------

  typedef enum logic [1:0] {
    FIND_MST_AWVALID_E,
    WAIT_MST_WLAST_E,
    WAIT_FOR_BVALID_E
  } arb_state_t;

endpackage

// ==== source/axi4_write_arbiter.sv ====
// Round-robin AXI4 write arbiter
// Holds one master's grant from address handshake to write response

`timescale 1ns/1ps

module axi4_write_arbiter #(
  parameter int AXI_ID_WIDTH_P   = 4,
  parameter int AXI_ADDR_WIDTH_P = 16,
  parameter int AXI_DATA_WIDTH_P = 32,
  parameter int AXI_STRB_WIDTH_P = 4,
  parameter int NR_OF_MASTERS_P  = 3
) (
  input  logic clk,
  input  logic rst_n,

  // Master write address channels
  input  logic [NR_OF_MASTERS_P-1:0][AXI_ID_WIDTH_P-1:0]   mst_awid,
  input  logic [NR_OF_MASTERS_P-1:0][AXI_ADDR_WIDTH_P-1:0] mst_awaddr,
  input  axi_wr_pkg::axi_len_t    [NR_OF_MASTERS_P-1:0]    mst_awlen,
  input  axi_wr_pkg::axi_size_t   [NR_OF_MASTERS_P-1:0]    mst_awsize,
  input  axi_wr_pkg::axi_burst_t  [NR_OF_MASTERS_P-1:0]    mst_awburst,
  input  axi_wr_pkg::axi_region_t [NR_OF_MASTERS_P-1:0]    mst_awregion,
  input  logic [NR_OF_MASTERS_P-1:0]                       mst_awvalid,
  output logic [NR_OF_MASTERS_P-1:0]                       mst_awready,

  // Master write data channels
  input  logic [NR_OF_MASTERS_P-1:0][AXI_DATA_WIDTH_P-1:0] mst_wdata,
  input  logic [NR_OF_MASTERS_P-1:0][AXI_STRB_WIDTH_P-1:0] mst_wstrb,
  input  logic [NR_OF_MASTERS_P-1:0]                       mst_wlast,
  input  logic [NR_OF_MASTERS_P-1:0]                       mst_wvalid,
  output logic [NR_OF_MASTERS_P-1:0]                       mst_wready,

  // Master write response, id and resp shared
  output logic [AXI_ID_WIDTH_P-1:0]                        mst_bid,
  output axi_wr_pkg::axi_resp_t                            mst_bresp,
  output logic [NR_OF_MASTERS_P-1:0]                       mst_bvalid,
  input  logic [NR_OF_MASTERS_P-1:0]                       mst_bready,

  // Slave write address channel
  output logic [AXI_ID_WIDTH_P-1:0]                        slv_awid,
  output logic [AXI_ADDR_WIDTH_P-1:0]                      slv_awaddr,
  output axi_wr_pkg::axi_len_t                             slv_awlen,
  output axi_wr_pkg::axi_size_t                            slv_awsize,
  output axi_wr_pkg::axi_burst_t                           slv_awburst,
  output axi_wr_pkg::axi_region_t                          slv_awregion,
  output logic                                             slv_awvalid,
  input  logic                                             slv_awready,

  // Slave write data channel
  output logic [AXI_DATA_WIDTH_P-1:0]                      slv_wdata,
  output logic [AXI_STRB_WIDTH_P-1:0]                      slv_wstrb,
  output logic                                             slv_wlast,
  output logic                                             slv_wvalid,
  input  logic                                             slv_wready,

  // Slave write response channel
  input  logic [AXI_ID_WIDTH_P-1:0]                        slv_bid,
  input  axi_wr_pkg::axi_resp_t                            slv_bresp,
  input  logic                                             slv_bvalid,
  output logic                                             slv_bready
);

  import axi_wr_pkg::*;

  // Master index width, at least one bit
  localparam int MST_W_C = (NR_OF_MASTERS_P > 1) ? $clog2(NR_OF_MASTERS_P) : 1;
  localparam logic [MST_W_C-1:0] LAST_MST_C = MST_W_C'(NR_OF_MASTERS_P - 1);

  arb_state_t         state_q;
  // Round-robin search position
  logic [MST_W_C-1:0] rotating_mst_q;
  // Multiplexer select
  logic [MST_W_C-1:0] selected_mst_q;
  // Multiplexer enable
  logic               granted_q;

  // --------------------------------------------------------------------
  // Grant FSM
  // --------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= FIND_MST_AWVALID_E;
      rotating_mst_q <= '0;
      selected_mst_q <= '0;
      granted_q      <= 1'b0;
    end else begin
      case (state_q)
        FIND_MST_AWVALID_E: begin
          // Step one master per cycle, wrap at the last one
          if (rotating_mst_q == LAST_MST_C) begin
            rotating_mst_q <= '0;
          end else begin
            rotating_mst_q <= rotating_mst_q + 1'b1;
          end
          // Pointed master requests, grant shows next cycle
          if (mst_awvalid[rotating_mst_q]) begin
            selected_mst_q <= rotating_mst_q;
            granted_q      <= 1'b1;
            state_q        <= WAIT_MST_WLAST_E;
          end
        end
        WAIT_MST_WLAST_E: begin
          if (slv_wvalid && slv_wready && slv_wlast) begin
            state_q <= WAIT_FOR_BVALID_E;
          end
        end
        WAIT_FOR_BVALID_E: begin
          // Release on response handshake, pointer already past served master
          if (slv_bvalid && slv_bready) begin
            granted_q <= 1'b0;
            state_q   <= FIND_MST_AWVALID_E;
          end
        end
        default: begin
          state_q <= FIND_MST_AWVALID_E;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------
  // Channel multiplexer
  // --------------------------------------------------------------------

  // Response payload broadcast, bvalid marks the owner
  assign mst_bid   = slv_bid;
  assign mst_bresp = slv_bresp;

  always_comb begin
    // Idle bus toward the slave
    slv_awid     = '0;
    slv_awaddr   = '0;
    slv_awlen    = '0;
    slv_awsize   = '0;
    slv_awburst  = '0;
    slv_awregion = '0;
    slv_awvalid  = 1'b0;
    slv_wdata    = '0;
    slv_wstrb    = '0;
    slv_wlast    = 1'b0;
    slv_wvalid   = 1'b0;
    slv_bready   = 1'b0;
    // Ungranted masters see no ready or bvalid
    mst_awready  = '0;
    mst_wready   = '0;
    mst_bvalid   = '0;

    if (granted_q) begin
      // Address channel
      slv_awid                    = mst_awid[selected_mst_q];
      slv_awaddr                  = mst_awaddr[selected_mst_q];
      slv_awlen                   = mst_awlen[selected_mst_q];
      slv_awsize                  = mst_awsize[selected_mst_q];
      slv_awburst                 = mst_awburst[selected_mst_q];
      slv_awregion                = mst_awregion[selected_mst_q];
      slv_awvalid                 = mst_awvalid[selected_mst_q];
      mst_awready[selected_mst_q] = slv_awready;
      // Data channel
      slv_wdata                   = mst_wdata[selected_mst_q];
      slv_wstrb                   = mst_wstrb[selected_mst_q];
      slv_wlast                   = mst_wlast[selected_mst_q];
      slv_wvalid                  = mst_wvalid[selected_mst_q];
      mst_wready[selected_mst_q]  = slv_wready;
      // Response channel
      mst_bvalid[selected_mst_q]  = slv_bvalid;
      slv_bready                  = mst_bready[selected_mst_q];
    end
  end

endmodule

// ==== source/axi4_write_slave.sv ====
// AXI4 write slave in front of a word RAM
// Steps INCR and FIXED burst addresses, drops out-of-range beats with SLVERR

`timescale 1ns/1ps

module axi4_write_slave #(
  parameter int AXI_ID_WIDTH_P   = 4,
  parameter int AXI_ADDR_WIDTH_P = 16,
  parameter int AXI_DATA_WIDTH_P = 32,
  parameter int AXI_STRB_WIDTH_P = 4,
  parameter int MEM_WORDS_P      = 256
) (
  input  logic clk,
  input  logic rst_n,

  // Write address channel
  input  logic [AXI_ID_WIDTH_P-1:0]       slv_awid,
  input  logic [AXI_ADDR_WIDTH_P-1:0]     slv_awaddr,
  input  axi_wr_pkg::axi_len_t            slv_awlen,
  input  axi_wr_pkg::axi_size_t           slv_awsize,
  input  axi_wr_pkg::axi_burst_t          slv_awburst,
  input  logic                            slv_awvalid,
  output logic                            slv_awready,

  // Write data channel
  input  logic [AXI_DATA_WIDTH_P-1:0]     slv_wdata,
  input  logic [AXI_STRB_WIDTH_P-1:0]     slv_wstrb,
  input  logic                            slv_wlast,
  input  logic                            slv_wvalid,
  output logic                            slv_wready,

  // Write response channel
  output logic [AXI_ID_WIDTH_P-1:0]       slv_bid,
  output axi_wr_pkg::axi_resp_t           slv_bresp,
  output logic                            slv_bvalid,
  input  logic                            slv_bready,

  // RAM write port
  output logic                            mem_we,
  output logic [$clog2(MEM_WORDS_P)-1:0]  mem_waddr,
  output logic [AXI_STRB_WIDTH_P-1:0]     mem_wstrb,
  output logic [AXI_DATA_WIDTH_P-1:0]     mem_wdata
);

  import axi_wr_pkg::*;

  localparam int MEM_ADDR_W_C = $clog2(MEM_WORDS_P);
  localparam logic [AXI_ADDR_WIDTH_P-1:0] MEM_WORDS_C = AXI_ADDR_WIDTH_P'(MEM_WORDS_P);

  typedef enum logic [1:0] {
    SLV_IDLE_E,
    SLV_DATA_E,
    SLV_RESP_E
  } slv_state_t;

  slv_state_t state_q;
  // Sticky range or length error
  logic       err_q;
  // Beats taken so far, one bit wider than len
  logic [8:0] beat_cnt_q;

  // Burst context, loaded on the address handshake
  logic [AXI_ID_WIDTH_P-1:0]   id_q;
  logic [AXI_ADDR_WIDTH_P-1:0] addr_q;
  axi_len_t                    len_q;
  axi_size_t                   size_q;
  axi_burst_t                  burst_q;

  logic                        aw_hs;
  logic                        w_hs;
  logic [AXI_ADDR_WIDTH_P-1:0] word_idx;
  logic                        beat_ok;

  assign aw_hs = slv_awvalid && slv_awready;
  assign w_hs  = slv_wvalid && slv_wready;

  // Byte address to word index, low bits ignored
  assign word_idx = addr_q >> 2;
  // Beat must land in the RAM and stay within awlen
  assign beat_ok  = (word_idx < MEM_WORDS_C) && (beat_cnt_q <= {1'b0, len_q});

  // --------------------------------------------------------------------
  // Channel handshakes
  // --------------------------------------------------------------------

  assign slv_awready = (state_q == SLV_IDLE_E);
  assign slv_wready  = (state_q == SLV_DATA_E);
  assign slv_bvalid  = (state_q == SLV_RESP_E);
  assign slv_bid     = id_q;
  assign slv_bresp   = err_q ? RESP_SLVERR : RESP_OKAY;

  // RAM write on the W handshake edge
  assign mem_we    = w_hs && beat_ok;
  assign mem_waddr = word_idx[MEM_ADDR_W_C-1:0];
  assign mem_wstrb = slv_wstrb;
  assign mem_wdata = slv_wdata;

  // --------------------------------------------------------------------
  // Control FSM
  // --------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= SLV_IDLE_E;
      err_q      <= 1'b0;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        SLV_IDLE_E: begin
          if (aw_hs) begin
            err_q      <= 1'b0;
            beat_cnt_q <= '0;
            state_q    <= SLV_DATA_E;
          end
        end
        SLV_DATA_E: begin
          if (w_hs) begin
            beat_cnt_q <= beat_cnt_q + 1'b1;
            if (!beat_ok) begin
              err_q <= 1'b1;
            end
            // Response follows the last beat
            if (slv_wlast) begin
              state_q <= SLV_RESP_E;
            end
          end
        end
        SLV_RESP_E: begin
          // Low bready stalls here
          if (slv_bready) begin
            state_q <= SLV_IDLE_E;
          end
        end
        default: begin
          state_q <= SLV_IDLE_E;
        end
      endcase
    end
  end

  // --------------------------------------------------------------------
  // Burst address stepping
  // --------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (aw_hs) begin
      id_q    <= slv_awid;
      addr_q  <= slv_awaddr;
      len_q   <= slv_awlen;
      size_q  <= slv_awsize;
      burst_q <= slv_awburst;
    end else if (w_hs && (burst_q != BURST_FIXED)) begin
      // INCR steps by the beat size, FIXED holds
      addr_q <= addr_q + (AXI_ADDR_WIDTH_P'(1) << size_q);
    end
  end

endmodule

// ==== source/axi_wr_mem.sv ====
// Word RAM behind the write slave
// Byte-enabled write port, combinational debug read port

`timescale 1ns/1ps

module axi_wr_mem #(
  parameter int AXI_DATA_WIDTH_P = 32,
  parameter int AXI_STRB_WIDTH_P = 4,
  parameter int MEM_WORDS_P      = 256
) (
  input  logic                           clk,
  input  logic                           rst_n,

  // Write port from the slave
  input  logic                           mem_we,
  input  logic [$clog2(MEM_WORDS_P)-1:0] mem_waddr,
  input  logic [AXI_STRB_WIDTH_P-1:0]    mem_wstrb,
  input  logic [AXI_DATA_WIDTH_P-1:0]    mem_wdata,

  // Debug read port
  input  logic [$clog2(MEM_WORDS_P)-1:0] dbg_addr,
  output logic [AXI_DATA_WIDTH_P-1:0]    dbg_data
);

  logic [AXI_DATA_WIDTH_P-1:0] mem_q [MEM_WORDS_P];

  // Cleared at reset for a known read-back
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < MEM_WORDS_P; w++) begin
        mem_q[w] <= '0;
      end
    end else if (mem_we) begin
      // Only strobed bytes change
      for (int b = 0; b < AXI_STRB_WIDTH_P; b++) begin
        if (mem_wstrb[b]) begin
          mem_q[mem_waddr][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

  assign dbg_data = mem_q[dbg_addr];

endmodule

// ==== source/axi_write_subsystem.sv ====
// Shared AXI4 write path top level
// Round-robin arbiter, write slave and word RAM

`timescale 1ns/1ps

module axi_write_subsystem #(
  parameter int AXI_ID_WIDTH_P   = 4,
  parameter int AXI_ADDR_WIDTH_P = 16,
  parameter int AXI_DATA_WIDTH_P = 32,
  parameter int AXI_STRB_WIDTH_P = 4,
  parameter int NR_OF_MASTERS_P  = 3,
  parameter int MEM_WORDS_P      = 256
) (
  input  logic clk,
  input  logic rst_n,

  // Master write address channels
  input  logic [NR_OF_MASTERS_P-1:0][AXI_ID_WIDTH_P-1:0]   mst_awid,
  input  logic [NR_OF_MASTERS_P-1:0][AXI_ADDR_WIDTH_P-1:0] mst_awaddr,
  input  axi_wr_pkg::axi_len_t    [NR_OF_MASTERS_P-1:0]    mst_awlen,
  input  axi_wr_pkg::axi_size_t   [NR_OF_MASTERS_P-1:0]    mst_awsize,
  input  axi_wr_pkg::axi_burst_t  [NR_OF_MASTERS_P-1:0]    mst_awburst,
  input  axi_wr_pkg::axi_region_t [NR_OF_MASTERS_P-1:0]    mst_awregion,
  input  logic [NR_OF_MASTERS_P-1:0]                       mst_awvalid,
  output logic [NR_OF_MASTERS_P-1:0]                       mst_awready,

  // Master write data channels
  input  logic [NR_OF_MASTERS_P-1:0][AXI_DATA_WIDTH_P-1:0] mst_wdata,
  input  logic [NR_OF_MASTERS_P-1:0][AXI_STRB_WIDTH_P-1:0] mst_wstrb,
  input  logic [NR_OF_MASTERS_P-1:0]                       mst_wlast,
  input  logic [NR_OF_MASTERS_P-1:0]                       mst_wvalid,
  output logic [NR_OF_MASTERS_P-1:0]                       mst_wready,

  // Master write response
  output logic [AXI_ID_WIDTH_P-1:0]                        mst_bid,
  output axi_wr_pkg::axi_resp_t                            mst_bresp,
  output logic [NR_OF_MASTERS_P-1:0]                       mst_bvalid,
  input  logic [NR_OF_MASTERS_P-1:0]                       mst_bready,

  // RAM inspection
  input  logic [$clog2(MEM_WORDS_P)-1:0]                   dbg_addr,
  output logic [AXI_DATA_WIDTH_P-1:0]                      dbg_data
);

  import axi_wr_pkg::*;

  // --------------------------------------------------------------------
  // Arbiter to slave channel
  // --------------------------------------------------------------------

  logic [AXI_ID_WIDTH_P-1:0]      slv_awid;
  logic [AXI_ADDR_WIDTH_P-1:0]    slv_awaddr;
  axi_len_t                       slv_awlen;
  axi_size_t                      slv_awsize;
  axi_burst_t                     slv_awburst;
  logic                           slv_awvalid;
  logic                           slv_awready;
  logic [AXI_DATA_WIDTH_P-1:0]    slv_wdata;
  logic [AXI_STRB_WIDTH_P-1:0]    slv_wstrb;
  logic                           slv_wlast;
  logic                           slv_wvalid;
  logic                           slv_wready;
  logic [AXI_ID_WIDTH_P-1:0]      slv_bid;
  axi_resp_t                      slv_bresp;
  logic                           slv_bvalid;
  logic                           slv_bready;

  // Slave to RAM write port
  logic                           mem_we;
  logic [$clog2(MEM_WORDS_P)-1:0] mem_waddr;
  logic [AXI_STRB_WIDTH_P-1:0]    mem_wstrb;
  logic [AXI_DATA_WIDTH_P-1:0]    mem_wdata;

  axi4_write_arbiter #(
    .AXI_ID_WIDTH_P   (AXI_ID_WIDTH_P),
    .AXI_ADDR_WIDTH_P (AXI_ADDR_WIDTH_P),
    .AXI_DATA_WIDTH_P (AXI_DATA_WIDTH_P),
    .AXI_STRB_WIDTH_P (AXI_STRB_WIDTH_P),
    .NR_OF_MASTERS_P  (NR_OF_MASTERS_P)
  ) u_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .mst_awid     (mst_awid),
    .mst_awaddr   (mst_awaddr),
    .mst_awlen    (mst_awlen),
    .mst_awsize   (mst_awsize),
    .mst_awburst  (mst_awburst),
    .mst_awregion (mst_awregion),
    .mst_awvalid  (mst_awvalid),
    .mst_awready  (mst_awready),
    .mst_wdata    (mst_wdata),
    .mst_wstrb    (mst_wstrb),
    .mst_wlast    (mst_wlast),
    .mst_wvalid   (mst_wvalid),
    .mst_wready   (mst_wready),
    .mst_bid      (mst_bid),
    .mst_bresp    (mst_bresp),
    .mst_bvalid   (mst_bvalid),
    .mst_bready   (mst_bready),
    .slv_awid     (slv_awid),
    .slv_awaddr   (slv_awaddr),
    .slv_awlen    (slv_awlen),
    .slv_awsize   (slv_awsize),
    .slv_awburst  (slv_awburst),
    // Region is not decoded by the single slave
    .slv_awregion (),
    .slv_awvalid  (slv_awvalid),
    .slv_awready  (slv_awready),
    .slv_wdata    (slv_wdata),
    .slv_wstrb    (slv_wstrb),
    .slv_wlast    (slv_wlast),
    .slv_wvalid   (slv_wvalid),
    .slv_wready   (slv_wready),
    .slv_bid      (slv_bid),
    .slv_bresp    (slv_bresp),
    .slv_bvalid   (slv_bvalid),
    .slv_bready   (slv_bready)
  );

  axi4_write_slave #(
    .AXI_ID_WIDTH_P   (AXI_ID_WIDTH_P),
    .AXI_ADDR_WIDTH_P (AXI_ADDR_WIDTH_P),
    .AXI_DATA_WIDTH_P (AXI_DATA_WIDTH_P),
    .AXI_STRB_WIDTH_P (AXI_STRB_WIDTH_P),
    .MEM_WORDS_P      (MEM_WORDS_P)
  ) u_slave (
    .clk         (clk),
    .rst_n       (rst_n),
    .slv_awid    (slv_awid),
    .slv_awaddr  (slv_awaddr),
    .slv_awlen   (slv_awlen),
    .slv_awsize  (slv_awsize),
    .slv_awburst (slv_awburst),
    .slv_awvalid (slv_awvalid),
    .slv_awready (slv_awready),
    .slv_wdata   (slv_wdata),
    .slv_wstrb   (slv_wstrb),
    .slv_wlast   (slv_wlast),
    .slv_wvalid  (slv_wvalid),
    .slv_wready  (slv_wready),
    .slv_bid     (slv_bid),
    .slv_bresp   (slv_bresp),
    .slv_bvalid  (slv_bvalid),
    .slv_bready  (slv_bready),
    .mem_we      (mem_we),
    .mem_waddr   (mem_waddr),
    .mem_wstrb   (mem_wstrb),
    .mem_wdata   (mem_wdata)
  );

  axi_wr_mem #(
    .AXI_DATA_WIDTH_P (AXI_DATA_WIDTH_P),
    .AXI_STRB_WIDTH_P (AXI_STRB_WIDTH_P),
    .MEM_WORDS_P      (MEM_WORDS_P)
  ) u_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wstrb (mem_wstrb),
    .mem_wdata (mem_wdata),
    .dbg_addr  (dbg_addr),
    .dbg_data  (dbg_data)
  );

endmodule

// ==== verif/tb_axi_write_subsystem.sv ====
// Testbench for the shared AXI4 write path
// Per-master burst drivers from a stimulus file, reference RAM, read-back sweep

`timescale 1ns/1ps

module tb_axi_write_subsystem;

  localparam int ID_W      = 4;
  localparam int ADDR_W    = 16;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = 4;
  localparam int NR_MST    = 3;
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = $clog2(MEM_WORDS);
  localparam int MAX_STIM  = 64;
  localparam string STIM_FILE = "verif/axi_write_stim.txt";
  // AXI4 response codes
  localparam logic [31:0] RESP_OKAY_C   = 32'd0;
  localparam logic [31:0] RESP_SLVERR_C = 32'd2;

  logic clk = 1'b0;
  logic rst_n;

  logic [NR_MST-1:0][ID_W-1:0]   mst_awid;
  logic [NR_MST-1:0][ADDR_W-1:0] mst_awaddr;
  logic [NR_MST-1:0][7:0]        mst_awlen;
  logic [NR_MST-1:0][2:0]        mst_awsize;
  logic [NR_MST-1:0][1:0]        mst_awburst;
  logic [NR_MST-1:0][3:0]        mst_awregion;
  logic [NR_MST-1:0]             mst_awvalid;
  logic [NR_MST-1:0]             mst_awready;
  logic [NR_MST-1:0][DATA_W-1:0] mst_wdata;
  logic [NR_MST-1:0][STRB_W-1:0] mst_wstrb;
  logic [NR_MST-1:0]             mst_wlast;
  logic [NR_MST-1:0]             mst_wvalid;
  logic [NR_MST-1:0]             mst_wready;
  logic [ID_W-1:0]               mst_bid;
  logic [1:0]                    mst_bresp;
  logic [NR_MST-1:0]             mst_bvalid;
  logic [NR_MST-1:0]             mst_bready;
  logic [MEM_AW-1:0]             dbg_addr;
  logic [DATA_W-1:0]             dbg_data;

  // Stimulus table with one row per burst
  int          s_test  [MAX_STIM];
  int          s_mst   [MAX_STIM];
  int          s_len   [MAX_STIM];
  int          s_burst [MAX_STIM];
  logic [31:0] s_id    [MAX_STIM];
  logic [31:0] s_addr  [MAX_STIM];
  logic [31:0] s_strb  [MAX_STIM];
  logic [31:0] s_data  [MAX_STIM];
  int          test_ids [$];
  int          n_stim;
  int          total_beats;

  // Reference RAM and words to sweep
  logic [31:0] ref_mem [MEM_WORDS];
  bit          touched [MEM_WORDS];

  int seed         = 32'h5cd7;
  int checks       = 0;
  int errors       = 0;
  int b_resp_count = 0;
  int cycles       = 0;
  int limit        = 1000000;

  // Previous mid-cycle bvalid sample
  logic [NR_MST-1:0] bvalid_prev = '0;

  axi_write_subsystem #(
    .AXI_ID_WIDTH_P   (ID_W),
    .AXI_ADDR_WIDTH_P (ADDR_W),
    .AXI_DATA_WIDTH_P (DATA_W),
    .AXI_STRB_WIDTH_P (STRB_W),
    .NR_OF_MASTERS_P  (NR_MST),
    .MEM_WORDS_P      (MEM_WORDS)
  ) DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .mst_awid     (mst_awid),
    .mst_awaddr   (mst_awaddr),
    .mst_awlen    (mst_awlen),
    .mst_awsize   (mst_awsize),
    .mst_awburst  (mst_awburst),
    .mst_awregion (mst_awregion),
    .mst_awvalid  (mst_awvalid),
    .mst_awready  (mst_awready),
    .mst_wdata    (mst_wdata),
    .mst_wstrb    (mst_wstrb),
    .mst_wlast    (mst_wlast),
    .mst_wvalid   (mst_wvalid),
    .mst_wready   (mst_wready),
    .mst_bid      (mst_bid),
    .mst_bresp    (mst_bresp),
    .mst_bvalid   (mst_bvalid),
    .mst_bready   (mst_bready),
    .dbg_addr     (dbg_addr),
    .dbg_data     (dbg_data)
  );

  // 8 ns clock
  always #4 clk = ~clk;

  // --------------------------------------------------------------------
  // Timeout and response counting
  // --------------------------------------------------------------------

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > limit) begin
      $display("TIMEOUT: no completion within %0d cycles", limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Each rising bvalid bit is one response offered to that master
  always @(negedge clk) begin
    if (rst_n) begin
      b_resp_count = b_resp_count + $countones(mst_bvalid & ~bvalid_prev);
    end
    bvalid_prev = mst_bvalid;
  end

  // --------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks = checks + 1;
    if (got !== exp) begin
      errors = errors + 1;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_stim(output bit ok);
    int          fd;
    int          cnt;
    string       line;
    int          t;
    int          m;
    int          len;
    int          burst;
    logic [31:0] id;
    logic [31:0] addr;
    logic [31:0] strb;
    logic [31:0] data;
    n_stim      = 0;
    total_beats = 0;
    ok          = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd) && n_stim < MAX_STIM) begin
        line = "";
        cnt  = $fgets(line, fd);
        // Comment and blank lines fail the scan
        if (cnt != 0 && $sscanf(line, "%d %d %h %h %d %d %h %h",
                                t, m, id, addr, len, burst, strb, data) == 8) begin
          if (m >= 0 && m < NR_MST) begin
            s_test[n_stim]  = t;
            s_mst[n_stim]   = m;
            s_id[n_stim]    = id;
            s_addr[n_stim]  = addr;
            s_len[n_stim]   = len;
            s_burst[n_stim] = burst;
            s_strb[n_stim]  = strb;
            s_data[n_stim]  = data;
            total_beats     = total_beats + len + 1;
            n_stim          = n_stim + 1;
            if (test_ids.size() == 0 || test_ids[$] != t) begin
              test_ids.push_back(t);
            end
          end
        end
      end
      $fclose(fd);
      ok = (n_stim > 0);
    end
  endtask

  // Reference write of one burst that returns 1 on any out-of-range beat
  function automatic bit apply_ref(input int i);
    int          addr;
    int          idx;
    bit          err;
    logic [31:0] beat;
    addr = s_addr[i];
    err  = 1'b0;
    for (int k = 0; k <= s_len[i]; k++) begin
      idx  = addr >> 2;
      beat = s_data[i] + k;
      if (idx < MEM_WORDS) begin
        for (int b = 0; b < STRB_W; b++) begin
          if (s_strb[i][b]) begin
            ref_mem[idx][8*b +: 8] = beat[8*b +: 8];
          end
        end
        touched[idx] = 1'b1;
      end else begin
        err = 1'b1;
        // Aliased word is swept too and must stay unchanged
        touched[idx % MEM_WORDS] = 1'b1;
      end
      // INCR steps one word and FIXED holds
      if (s_burst[i] == 1) begin
        addr = addr + 4;
      end
    end
    return err;
  endfunction

  // --------------------------------------------------------------------
  // Master driver
  // --------------------------------------------------------------------

  // Entered and left 1 ns after a rising edge
  task automatic drive_burst(input int m, input int i);
    int          k;
    logic [31:0] exp_resp;
    exp_resp = apply_ref(i) ? RESP_SLVERR_C : RESP_OKAY_C;
    // Address phase
    mst_awid[m]    = s_id[i][ID_W-1:0];
    mst_awaddr[m]  = s_addr[i][ADDR_W-1:0];
    mst_awlen[m]   = 8'(s_len[i]);
    mst_awburst[m] = 2'(s_burst[i]);
    mst_awvalid[m] = 1'b1;
    @(negedge clk);
    while (!mst_awready[m]) begin
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    mst_awvalid[m] = 1'b0;
    // Data beats
    for (k = 0; k <= s_len[i]; k++) begin
      mst_wdata[m]  = s_data[i] + k;
      mst_wstrb[m]  = s_strb[i][STRB_W-1:0];
      mst_wlast[m]  = (k == s_len[i]);
      mst_wvalid[m] = 1'b1;
      @(negedge clk);
      while (!mst_wready[m]) begin
        @(negedge clk);
      end
      @(posedge clk);
      #1;
    end
    mst_wvalid[m] = 1'b0;
    mst_wlast[m]  = 1'b0;
    // Response with random bready stalls
    mst_bready[m] = ($random(seed) & 32'h3) != 0;
    @(negedge clk);
    while (!(mst_bvalid[m] && mst_bready[m])) begin
      @(posedge clk);
      #1;
      mst_bready[m] = ($random(seed) & 32'h3) != 0;
      @(negedge clk);
    end
    check_value($sformatf("master %0d bid", m), 32'(mst_bid), s_id[i]);
    check_value($sformatf("master %0d bresp", m), 32'(mst_bresp), exp_resp);
    check_value($sformatf("bvalid beside master %0d", m),
                32'(mst_bvalid & ~(NR_MST'(1) << m)), 32'd0);
    @(posedge clk);
    #1;
    mst_bready[m] = 1'b0;
  endtask

  // One master's bursts of one test in file order
  task automatic run_master(input int m, input int t);
    for (int i = 0; i < n_stim; i++) begin
      if (s_test[i] == t && s_mst[i] == m) begin
        drive_burst(m, i);
      end
    end
  endtask

  task automatic sweep_memory(output int words);
    words = 0;
    for (int w = 0; w < MEM_WORDS; w++) begin
      if (touched[w]) begin
        @(posedge clk);
        #1;
        dbg_addr = MEM_AW'(w);
        @(negedge clk);
        check_value($sformatf("word %0d", w), dbg_data, ref_mem[w]);
        words = words + 1;
      end
    end
  endtask

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------

  initial begin
    bit ok;
    int bursts;
    int words;
    int err_before;
    rst_n        = 1'b0;
    mst_awid     = '0;
    mst_awaddr   = '0;
    mst_awlen    = '0;
    mst_awsize   = {NR_MST{3'd2}};
    mst_awburst  = '0;
    mst_awregion = '0;
    mst_awvalid  = '0;
    mst_wdata    = '0;
    mst_wstrb    = '0;
    mst_wlast    = '0;
    mst_wvalid   = '0;
    mst_bready   = '0;
    dbg_addr     = '0;
    for (int w = 0; w < MEM_WORDS; w++) begin
      ref_mem[w] = '0;
      touched[w] = 1'b0;
    end
    load_stim(ok);
    if (!ok) begin
      $display("Could not read any transactions from %s", STIM_FILE);
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      limit = 64 * total_beats + 200;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      foreach (test_ids[n]) begin
        err_before = errors;
        bursts     = 0;
        for (int i = 0; i < n_stim; i++) begin
          if (s_test[i] == test_ids[n]) begin
            bursts = bursts + 1;
          end
        end
        @(posedge clk);
        #1;
        // All three masters start together
        fork
          run_master(0, test_ids[n]);
          run_master(1, test_ids[n]);
          run_master(2, test_ids[n]);
        join
        sweep_memory(words);
        $display("test %0d: %0d bursts, %0d words read back, %0d errors",
                 test_ids[n], bursts, words, errors - err_before);
      end
      // Each burst answered exactly once
      check_value("response count", 32'(b_resp_count), 32'(n_stim));
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
      $finish;
    end
  end

endmodule

// ==== axi_write_subsystem.f ====
source/axi_wr_pkg.sv
source/axi4_write_arbiter.sv
source/axi4_write_slave.sv
source/axi_wr_mem.sv
source/axi_write_subsystem.sv
verif/tb_axi_write_subsystem.sv

// ==== Makefile ====
# Verilator build and run of the shared AXI4 write path testbench

TOP     = tb_axi_write_subsystem
SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f axi_write_subsystem.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee $(SIM_LOG)
	@grep -q -F "*** TEST PASSED ***" $(SIM_LOG) || \
		(echo "Simulation did not pass, see $(SIM_LOG)"; exit 1)

clean:
	rm -rf obj_dir $(SIM_LOG)

// ==== verif/axi_write_stim.txt ====
# test master id(hex) addr(hex) len burst(0=FIXED 1=INCR) strb(hex) data(hex)
# Beat k writes data+k; lines with the same test number run together
# Single-beat INCR from each master
1 0 1 0010 0 1 f 11110000
1 1 2 0020 0 1 f 22220000
1 2 3 0030 0 1 f 33330000
# Eight-beat INCR burst
2 1 5 0100 7 1 f a0000000
# Four-beat FIXED burst, last beat stays
3 2 6 0200 3 0 f c0de0000
# Partial strobes over one word, then a two-beat strobed burst
4 0 7 0300 0 1 f 11223344
4 0 7 0300 0 1 3 aabbccdd
4 0 8 0300 0 1 4 55667788
4 0 9 0304 1 1 9 deadbe00
# Burst across the RAM end, and a FIXED burst fully outside
5 1 a 03f8 3 1 f e0000000
5 2 b 0400 1 0 f f0000000
# All masters at once, disjoint words
6 0 c 0040 5 1 f 60000000
6 1 d 0080 3 1 f 61000000
6 2 e 00c0 6 1 f 62000000
6 0 4 0060 1 1 f 63000000
6 1 9 00a0 2 0 f 64000000
6 2 f 00e0 0 1 7 65000000
